/* src.f */
rtl/mipsPkg.sv
rtl/cpuController.sv
rtl/programCounter.sv
rtl/registerFile.sv
rtl/executeUnit.sv
rtl/mipsCpu.sv
dv/mipsCpuTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := mipsCpuTb
RTL_TOP   := mipsCpu
FILELIST  := src.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing -Wno-fatal
LINTFLAGS := --lint-only -Wall --timing
PASS_MSG  := === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* dv/mipsCpuTb.sv */
//####################################################################
// Testbench for the MIPS I subset CPU
// Random program from a fixed seed, Avalon memory with random
// waitrequest, ISA reference model, bus order and halt checks
//####################################################################

`timescale 1ns/100ps

module mipsCpuTb;

    localparam int numInstrs     = 200;
    localparam int timeoutCycles = numInstrs * 12 + 100;
    localparam logic [31:0] dataBase = 32'h0000_2000;  // Kept in $28

    typedef struct packed {
        logic        isWrite;
        logic [31:0] address;
        logic [31:0] data;
    } accessT;

    typedef struct packed {
        logic [31:0] address;
        logic        read;
        logic        write;
        logic [31:0] writedata;
    } busT;

    logic        clk;
    logic        reset;
    logic        waitrequest;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [31:0] readdata;

    logic [31:0] mem      [logic [31:0]];
    logic [31:0] modelMem [logic [31:0]];
    logic [31:0] modelRegs [32];
    accessT      expected [$];
    int unsigned waitTable [1024];

    int  errorCount;
    int  checkCount;
    int  accessCount;
    int  accessIndex;
    int  cycleCount;
    int  waitLeft;
    bit  timedOut;
    bit  sawFirst;
    bit  held;
    busT heldBus;

    mipsCpu mipsCpu_i (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .read        (read),
        .write       (write),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .readdata    (readdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Unwritten words still read back as a pattern of the full address
    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h9E37_79B9;
    endfunction

    function automatic logic [31:0] busLookup(input logic [31:0] addr);
        return mem.exists(addr) ? mem[addr] : fillWord(addr);
    endfunction

    function automatic logic [31:0] modelLookup(input logic [31:0] addr);
        return modelMem.exists(addr) ? modelMem[addr] : fillWord(addr);
    endfunction

    assign readdata = busLookup(address);

    function automatic logic [31:0] rWord(input logic [5:0] funct, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] shamt);
        return {6'd0, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic compareWord(input string testName, input logic [31:0] expectedValue,
                               input logic [31:0] actualValue);
        checkCount++;
        if (actualValue !== expectedValue) begin
            errorCount++;
            $display("Fail %s: expected %h, actual %h", testName, expectedValue, actualValue);
        end
    endtask

    task automatic expectAccess(input logic isWrite, input logic [31:0] addr,
                                input logic [31:0] data);
        accessT entry;
        entry.isWrite = isWrite;
        entry.address = addr;
        entry.data    = data;
        expected.push_back(entry);
    endtask

    task automatic finishRun();
        $display("Checks: %0d, errors: %0d, timeout: %0d", checkCount, errorCount, timedOut);
        if (errorCount == 0 && !timedOut) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    task automatic buildProgram();
        logic [5:0]  rFuncts [10];
        logic [5:0]  iOps [7];
        logic [31:0] word;
        logic [31:0] target;
        logic [15:0] memOffset;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        int          kind;
        int          span;
        int          off;
        rFuncts = '{mipsPkg::FN_ADDU, mipsPkg::FN_SUBU, mipsPkg::FN_AND, mipsPkg::FN_OR,
                    mipsPkg::FN_XOR, mipsPkg::FN_SLT, mipsPkg::FN_SLTU, mipsPkg::FN_SLL,
                    mipsPkg::FN_SRL, mipsPkg::FN_SRA};
        iOps = '{mipsPkg::OP_ADDIU, mipsPkg::OP_SLTI, mipsPkg::OP_SLTIU, mipsPkg::OP_ANDI,
                 mipsPkg::OP_ORI, mipsPkg::OP_XORI, mipsPkg::OP_LUI};
        for (int k = 0; k < 256; k++) begin
            mem[dataBase - 32'd512 + 32'(4 * k)] = $urandom;  // Data window around $28
        end
        mem[mipsPkg::resetVector] = iWord(mipsPkg::OP_ORI, 5'd0, 5'd28, dataBase[15:0]);
        for (int i = 1; i < numInstrs - 1; i++) begin
            rs        = 5'($urandom_range(31, 0));
            rt        = 5'($urandom_range(31, 0));
            rd        = 5'($urandom_range(27, 0));  // Never clobbers the base
            kind      = $urandom_range(19, 0);
            memOffset = 16'(($urandom_range(255, 0) << 2) - 512);
            span      = numInstrs - 2 - i;
            if (span > 3) begin
                span = 3;
            end
            off = $urandom_range(span, 0);  // Forward only, never past the final JR
            if ($urandom_range(3, 0) == 0) begin
                rt = rs;  // Some equal operands for the branches
            end
            if (kind <= 6) begin
                word = rWord(rFuncts[$urandom_range(9, 0)], rs, rt, rd,
                             5'($urandom_range(31, 0)));
            end else if (kind <= 11) begin
                word = iWord(iOps[$urandom_range(6, 0)], rs, rd, 16'($urandom));
            end else if (kind <= 13) begin
                word = iWord(mipsPkg::OP_LW, 5'd28, rd, memOffset);
            end else if (kind <= 15) begin
                word = iWord(mipsPkg::OP_SW, 5'd28, rt, memOffset);
            end else if (kind <= 17) begin
                word = iWord(mipsPkg::OP_BEQ, rs, rt, 16'(off));
            end else if (kind == 18) begin
                word = iWord(mipsPkg::OP_BNE, rs, rt, 16'(off));
            end else begin
                target = mipsPkg::resetVector + 32'(4 * (i + 1 + off));
                word   = {mipsPkg::OP_J, target[27:2]};
            end
            mem[mipsPkg::resetVector + 32'(4 * i)] = word;
        end
        // JR $0 ends the program
        mem[mipsPkg::resetVector + 32'(4 * (numInstrs - 1))] =
            rWord(mipsPkg::FN_JR, 5'd0, 5'd0, 5'd0, 5'd0);
    endtask

    // Instruction set reference, records every bus access in order
    task automatic runModel();
        logic [31:0] pc;
        logic [31:0] ir;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] value;
        logic [31:0] nextPc;
        logic [4:0]  dest;
        bit          writes;
        bit          halted;
        int          steps;
        pc     = mipsPkg::resetVector;
        halted = 1'b0;
        steps  = 0;
        foreach (modelRegs[r]) begin
            modelRegs[r] = '0;
        end
        while (!halted && steps < 4 * numInstrs) begin
            ir = modelLookup(pc);
            expectAccess(1'b0, pc, 32'h0);
            a      = modelRegs[ir[25:21]];
            b      = modelRegs[ir[20:16]];
            sext   = {{16{ir[15]}}, ir[15:0]};
            zext   = {16'h0000, ir[15:0]};
            nextPc = pc + 32'd4;
            writes = 1'b1;
            dest   = ir[20:16];
            value  = '0;
            case (ir[31:26])
                mipsPkg::OP_SPECIAL: begin
                    dest = ir[15:11];
                    case (ir[5:0])
                        mipsPkg::FN_ADDU: value = a + b;
                        mipsPkg::FN_SUBU: value = a - b;
                        mipsPkg::FN_AND:  value = a & b;
                        mipsPkg::FN_OR:   value = a | b;
                        mipsPkg::FN_XOR:  value = a ^ b;
                        mipsPkg::FN_SLT:  value = 32'($signed(a) < $signed(b));
                        mipsPkg::FN_SLTU: value = 32'(a < b);
                        mipsPkg::FN_SLL:  value = b << ir[10:6];
                        mipsPkg::FN_SRL:  value = b >> ir[10:6];
                        mipsPkg::FN_SRA:  value = $signed(b) >>> ir[10:6];
                        mipsPkg::FN_JR: begin
                            writes = 1'b0;
                            nextPc = a;
                            halted = a == mipsPkg::haltAddress;
                        end
                        default: writes = 1'b0;
                    endcase
                end
                mipsPkg::OP_ADDIU: value = a + sext;
                mipsPkg::OP_SLTI:  value = 32'($signed(a) < $signed(sext));
                mipsPkg::OP_SLTIU: value = 32'(a < sext);
                mipsPkg::OP_ANDI:  value = a & zext;
                mipsPkg::OP_ORI:   value = a | zext;
                mipsPkg::OP_XORI:  value = a ^ zext;
                mipsPkg::OP_LUI:   value = {ir[15:0], 16'h0000};
                mipsPkg::OP_LW: begin
                    value = modelLookup(a + sext);
                    expectAccess(1'b0, a + sext, 32'h0);
                end
                mipsPkg::OP_SW: begin
                    writes = 1'b0;
                    modelMem[a + sext] = b;
                    expectAccess(1'b1, a + sext, b);
                end
                mipsPkg::OP_BEQ: begin
                    writes = 1'b0;
                    if (a == b) nextPc = pc + 32'd4 + (sext << 2);
                end
                mipsPkg::OP_BNE: begin
                    writes = 1'b0;
                    if (a != b) nextPc = pc + 32'd4 + (sext << 2);
                end
                mipsPkg::OP_J: begin
                    writes = 1'b0;
                    nextPc = {nextPc[31:28], ir[25:0], 2'b00};
                    halted = nextPc == mipsPkg::haltAddress;
                end
                default: writes = 1'b0;
            endcase
            if (writes && dest != 5'd0) begin
                modelRegs[dest] = value;
            end
            pc = nextPc;
            steps++;
        end
    endtask

    // Avalon slave side, waits are picked per access from the table
    always @(posedge clk) begin
        if (reset) begin
            accessCount = 0;
            waitLeft    = waitTable[0];
            waitrequest <= waitLeft != 0;
        end else if ((read || write) && !waitrequest) begin
            if (write) mem[address] = writedata;
            accessCount++;
            waitLeft = waitTable[accessCount % 1024];
            waitrequest <= waitLeft != 0;
        end else if ((read || write) && waitLeft > 0) begin
            waitLeft--;
            if (waitLeft == 0) waitrequest <= 1'b0;
        end
    end

    always @(posedge clk) begin : busMonitor
        accessT want;
        busT    now;
        if (reset) begin
            held = 1'b0;
        end else begin
            now = '{address, read, write, writedata};
            if (!sawFirst && (read || write)) begin
                sawFirst = 1'b1;
                compareWord("first access read", 32'd1, 32'(read));
                compareWord("first access write", 32'd0, 32'(write));
                compareWord("first access address", mipsPkg::resetVector, address);
            end
            if (held) begin
                compareWord("held address", heldBus.address, address);
                compareWord("held strobes", {30'd0, heldBus.read, heldBus.write},
                            {30'd0, read, write});
                compareWord("held writedata", heldBus.writedata, writedata);
            end
            held    = (read || write) && waitrequest;
            heldBus = now;
            if ((read || write) && !waitrequest) begin
                if (expected.size() == 0) begin
                    errorCount++;
                    $display("Unexpected bus access at %h after the program end", address);
                end else begin
                    want = expected.pop_front();
                    compareWord($sformatf("access %0d write", accessIndex),
                                32'(want.isWrite), 32'(write));
                    compareWord($sformatf("access %0d address", accessIndex),
                                want.address, address);
                    if (want.isWrite) begin
                        compareWord($sformatf("access %0d store data", accessIndex),
                                    want.data, writedata);
                    end
                end
                accessIndex++;
            end
            if (active) cycleCount++;
            if (cycleCount >= timeoutCycles) begin
                timedOut = 1'b1;
                $display("Timeout: the CPU did not halt within %0d cycles", timeoutCycles);
                finishRun();
            end
        end
    end

    initial begin
        reset       = 1'b1;
        waitrequest = 1'b0;
        errorCount  = 0;
        checkCount  = 0;
        accessIndex = 0;
        cycleCount  = 0;
        timedOut    = 1'b0;
        sawFirst    = 1'b0;
        void'($urandom(32'hfb1978d0));
        foreach (waitTable[n]) begin
            waitTable[n] = $urandom_range(3, 0);
        end
        buildProgram();
        foreach (mem[a]) begin
            modelMem[a] = mem[a];
        end
        runModel();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        do @(posedge clk); while (active === 1'b1);
        repeat (20) begin
            @(posedge clk);
            if (read || write || active) begin
                errorCount++;
                $display("Bus strobe or active seen after the CPU halted");
            end
        end
        if (expected.size() != 0) begin
            errorCount++;
            $display("%0d predicted bus accesses never happened", expected.size());
        end
        compareWord("register_v0 after halt", modelRegs[2], register_v0);
        finishRun();
    end

endmodule

/* rtl/mipsCpu.sv */
//####################################################################
// MIPS I subset CPU, top level
// Multicycle core with an Avalon memory master, built from the
// control FSM, program counter, register file and execute unit
//####################################################################

`timescale 1ns/100ps

module mipsCpu (
    input  logic                          clk,
    input  logic                          reset,
    output logic                          active,
    output logic [mipsPkg::dataWidth-1:0] register_v0,

    // Avalon master
    output logic [mipsPkg::dataWidth-1:0] address,
    output logic                          read,
    output logic                          write,
    input  logic                          waitrequest,
    output logic [mipsPkg::dataWidth-1:0] writedata,
    input  logic [mipsPkg::dataWidth-1:0] readdata
);

    mipsPkg::instrWordT            instr;
    mipsPkg::cpuCtrlT              ctrl;
    logic [mipsPkg::dataWidth-1:0] pc;
    logic [mipsPkg::dataWidth-1:0] result;
    logic [mipsPkg::dataWidth-1:0] rsData;
    logic [mipsPkg::dataWidth-1:0] rtData;
    logic                          branchTaken;

    assign writedata = rtData;  // SW stores rt

    cpuController cpuController_i (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .pc          (pc),
        .result      (result),
        .branchTaken (branchTaken),
        .instr       (instr),
        .ctrl        (ctrl),
        .address     (address),
        .read        (read),
        .write       (write),
        .active      (active)
    );

    programCounter programCounter_i (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .instr      (instr),
        .jumpTarget (rsData),
        .pc         (pc)
    );

    registerFile registerFile_i (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .ctrl      (ctrl),
        .writeData (result),
        .rsData    (rsData),
        .rtData    (rtData),
        .v0        (register_v0)
    );

    executeUnit executeUnit_i (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .ctrl        (ctrl),
        .pc          (pc),
        .rsData      (rsData),
        .rtData      (rtData),
        .readdata    (readdata),
        .result      (result),
        .branchTaken (branchTaken)
    );

endmodule

/* rtl/executeUnit.sv */
//####################################################################
// Execute unit
// ALU, shifter and compares for the R and I formats, load/store
// address and jump target, BEQ/BNE condition, and the result register
// that also takes load data
//####################################################################

`timescale 1ns/100ps

module executeUnit (
    input  logic                          clk,
    input  logic                          reset,
    input  mipsPkg::instrWordT            instr,
    input  mipsPkg::cpuCtrlT              ctrl,
    input  logic [mipsPkg::dataWidth-1:0] pc,
    input  logic [mipsPkg::dataWidth-1:0] rsData,
    input  logic [mipsPkg::dataWidth-1:0] rtData,
    input  logic [mipsPkg::dataWidth-1:0] readdata,
    output logic [mipsPkg::dataWidth-1:0] result,
    output logic                          branchTaken
);

    localparam int zeroPad = mipsPkg::dataWidth - 1;

    logic [mipsPkg::dataWidth-1:0] immSext;
    logic [mipsPkg::dataWidth-1:0] immZext;
    logic [mipsPkg::dataWidth-1:0] pcPlus4;
    logic [mipsPkg::dataWidth-1:0] aluOut;

    assign immSext = {{16{instr.i.imm16[15]}}, instr.i.imm16};
    assign immZext = {16'h0000, instr.i.imm16};
    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        aluOut = '0;
        if (instr.r.opcode == mipsPkg::OP_SPECIAL) begin
            case (instr.r.funct)
                mipsPkg::FN_ADDU: aluOut = rsData + rtData;
                mipsPkg::FN_SUBU: aluOut = rsData - rtData;
                mipsPkg::FN_AND:  aluOut = rsData & rtData;
                mipsPkg::FN_OR:   aluOut = rsData | rtData;
                mipsPkg::FN_XOR:  aluOut = rsData ^ rtData;
                mipsPkg::FN_SLT:  aluOut = {{zeroPad{1'b0}}, $signed(rsData) < $signed(rtData)};
                mipsPkg::FN_SLTU: aluOut = {{zeroPad{1'b0}}, rsData < rtData};
                mipsPkg::FN_SLL:  aluOut = rtData << instr.r.shamt;
                mipsPkg::FN_SRL:  aluOut = rtData >> instr.r.shamt;
                mipsPkg::FN_SRA:  aluOut = $signed(rtData) >>> instr.r.shamt;
                mipsPkg::FN_JR:   aluOut = rsData;  // Target for the halt check
                default:          aluOut = '0;
            endcase
        end else begin
            case (instr.i.opcode)
                mipsPkg::OP_ADDIU,
                mipsPkg::OP_LW,
                mipsPkg::OP_SW:    aluOut = rsData + immSext;
                mipsPkg::OP_SLTI:  aluOut = {{zeroPad{1'b0}}, $signed(rsData) < $signed(immSext)};
                mipsPkg::OP_SLTIU: aluOut = {{zeroPad{1'b0}}, rsData < immSext};
                mipsPkg::OP_ANDI:  aluOut = rsData & immZext;
                mipsPkg::OP_ORI:   aluOut = rsData | immZext;
                mipsPkg::OP_XORI:  aluOut = rsData ^ immZext;
                mipsPkg::OP_LUI:   aluOut = {instr.i.imm16, 16'h0000};
                mipsPkg::OP_J:     aluOut = {pcPlus4[31:28], instr.j.target26, 2'b00};
                default:           aluOut = '0;
            endcase
        end
    end

    always_comb begin
        case (instr.i.opcode)
            mipsPkg::OP_BEQ: branchTaken = rsData == rtData;
            mipsPkg::OP_BNE: branchTaken = rsData != rtData;
            default:         branchTaken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (ctrl.loadCapture) begin
            result <= readdata;  // LW data on to writeback
        end else if (ctrl.resultLoad) begin
            result <= aluOut;
        end
    end

endmodule

/* rtl/registerFile.sv */
//####################################################################
// Register file
// 32 general purpose registers, two combinational read ports
// addressed by rs and rt, one write port, register 0 reads as zero
//####################################################################

`timescale 1ns/100ps

module registerFile (
    input  logic                          clk,
    input  logic                          reset,
    input  mipsPkg::instrWordT            instr,
    input  mipsPkg::cpuCtrlT              ctrl,
    input  logic [mipsPkg::dataWidth-1:0] writeData,
    output logic [mipsPkg::dataWidth-1:0] rsData,
    output logic [mipsPkg::dataWidth-1:0] rtData,
    output logic [mipsPkg::dataWidth-1:0] v0
);

    localparam int numRegs = 2 ** mipsPkg::regAddrWidth;

    logic [mipsPkg::dataWidth-1:0] regs [numRegs];

    assign rsData = regs[instr.r.rs];
    assign rtData = regs[instr.r.rt];
    assign v0     = regs[2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite && ctrl.destReg != '0) begin
            regs[ctrl.destReg] <= writeData;  // $zero is never written
        end
    end

endmodule

/* rtl/programCounter.sv */
//####################################################################
// Program counter
// Starts at the reset vector, then steps by one word, takes
// PC-relative branches or loads a J or JR jump target
//####################################################################

`timescale 1ns/100ps

module programCounter (
    input  logic                          clk,
    input  logic                          reset,
    input  mipsPkg::cpuCtrlT              ctrl,
    input  mipsPkg::instrWordT            instr,
    input  logic [mipsPkg::dataWidth-1:0] jumpTarget,  // rs value for JR
    output logic [mipsPkg::dataWidth-1:0] pc
);

    logic [mipsPkg::dataWidth-1:0] pcPlus4;
    logic [mipsPkg::dataWidth-1:0] branchOffset;
    logic [mipsPkg::dataWidth-1:0] regionTarget;

    assign pcPlus4 = pc + 32'd4;

    // Sign-extended word offset
    assign branchOffset = {{14{instr.i.imm16[15]}}, instr.i.imm16, 2'b00};

    // J stays inside the current 256 MB region
    assign regionTarget = {pcPlus4[31:28], instr.j.target26, 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= mipsPkg::resetVector;
        end else if (ctrl.pcJump) begin
            // Only JR among the jumps is SPECIAL
            if (instr.r.opcode == mipsPkg::OP_SPECIAL) begin
                pc <= jumpTarget;
            end else begin
                pc <= regionTarget;
            end
        end else if (ctrl.pcBranch) begin
            pc <= pcPlus4 + branchOffset;
        end else if (ctrl.pcAdvance) begin
            pc <= pcPlus4;
        end
    end

endmodule

/* rtl/cpuController.sv */
//####################################################################
// CPU control FSM
// Sequences fetch, decode, execute, memory and writeback, holds the
// instruction register, drives the Avalon master strobes and stops
// the core when a jump lands on the halt address
//####################################################################

`timescale 1ns/100ps

module cpuController (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              waitrequest,
    input  logic [mipsPkg::dataWidth-1:0]     readdata,
    input  logic [mipsPkg::dataWidth-1:0]     pc,
    input  logic [mipsPkg::dataWidth-1:0]     result,
    input  logic                              branchTaken,
    output mipsPkg::instrWordT                instr,
    output mipsPkg::cpuCtrlT                  ctrl,
    output logic [mipsPkg::dataWidth-1:0]     address,
    output logic                              read,
    output logic                              write,
    output logic                              active
);

    mipsPkg::cpuStateT state;

    logic isRType;
    logic isJump;
    logic isBranch;
    logic isLoad;
    logic isStore;
    logic busDone;

    assign isRType  = instr.r.opcode == mipsPkg::OP_SPECIAL;
    assign isJump   = instr.j.opcode == mipsPkg::OP_J || (isRType && instr.r.funct == mipsPkg::FN_JR);
    assign isBranch = instr.i.opcode == mipsPkg::OP_BEQ || instr.i.opcode == mipsPkg::OP_BNE;
    assign isLoad   = instr.i.opcode == mipsPkg::OP_LW;
    assign isStore  = instr.i.opcode == mipsPkg::OP_SW;
    assign busDone  = (read || write) && !waitrequest;

    // Result is first loaded in DECODE, so a jump target is visible in EXECUTE
    always_comb begin
        ctrl             = '0;
        ctrl.pcJump      = state == mipsPkg::EXECUTE && isJump;
        ctrl.pcBranch    = state == mipsPkg::EXECUTE && isBranch && branchTaken;
        ctrl.pcAdvance   = state == mipsPkg::EXECUTE && !isJump && !(isBranch && branchTaken);
        ctrl.resultLoad  = state == mipsPkg::DECODE || state == mipsPkg::EXECUTE;
        ctrl.loadCapture = state == mipsPkg::MEMORY && isLoad && busDone;
        ctrl.regWrite    = state == mipsPkg::WRITEBACK;
        ctrl.destReg     = isRType ? instr.r.rd : instr.i.rt;
    end

    assign address = (state == mipsPkg::MEMORY) ? result : pc;
    assign active  = state != mipsPkg::HALT;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mipsPkg::FETCH;
            read  <= 1'b0;
            write <= 1'b0;
        end else begin
            case (state)
                mipsPkg::FETCH: begin
                    if (!read) begin
                        read <= 1'b1;  // First fetch after reset
                    end else if (!waitrequest) begin
                        read  <= 1'b0;
                        state <= mipsPkg::DECODE;
                    end
                end
                mipsPkg::DECODE: state <= mipsPkg::EXECUTE;
                mipsPkg::EXECUTE: begin
                    if (isJump && result == mipsPkg::haltAddress) begin
                        state <= mipsPkg::HALT;
                    end else if (isJump || isBranch) begin
                        state <= mipsPkg::FETCH;
                        read  <= 1'b1;
                    end else if (isLoad || isStore) begin
                        state <= mipsPkg::MEMORY;
                        read  <= isLoad;
                        write <= isStore;
                    end else begin
                        state <= mipsPkg::WRITEBACK;
                    end
                end
                mipsPkg::MEMORY: begin
                    if (busDone) begin
                        write <= 1'b0;
                        read  <= isStore;  // Store goes straight on to the next fetch
                        state <= isStore ? mipsPkg::FETCH : mipsPkg::WRITEBACK;
                    end
                end
                mipsPkg::WRITEBACK: begin
                    state <= mipsPkg::FETCH;
                    read  <= 1'b1;
                end
                default: state <= mipsPkg::HALT;
            endcase
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (state == mipsPkg::FETCH && read && !waitrequest) begin
            instr <= mipsPkg::instrWordT'(readdata);
        end
    end

endmodule

/* rtl/mipsPkg.sv */
//####################################################################
// MIPS CPU shared definitions
// Word and register widths, reset and halt addresses, opcode and
// function encodings, FSM states, the instruction word with its
// R, I and J views, and the control strobe bundle
//####################################################################

package mipsPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;

    localparam logic [dataWidth-1:0] resetVector = 32'hBFC0_0000;
    localparam logic [dataWidth-1:0] haltAddress = 32'h0000_0000;

    // Primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0,   // R-type, decoded by funct
        OP_J       = 6'd2,
        OP_BEQ     = 6'd4,
        OP_BNE     = 6'd5,
        OP_ADDIU   = 6'd9,
        OP_SLTI    = 6'd10,
        OP_SLTIU   = 6'd11,
        OP_ANDI    = 6'd12,
        OP_ORI     = 6'd13,
        OP_XORI    = 6'd14,
        OP_LUI     = 6'd15,
        OP_LW      = 6'd35,
        OP_SW      = 6'd43
    } opcodeT;

    // SPECIAL function codes, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } functT;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALT
    } cpuStateT;

    typedef struct packed {
        opcodeT                  opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [4:0]              shamt;
        functT                   funct;
    } rFormatT;

    typedef struct packed {
        opcodeT                  opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [15:0]             imm16;
    } iFormatT;

    typedef struct packed {
        opcodeT      opcode;
        logic [25:0] target26;
    } jFormatT;

    // One fetched word, read through whichever format the opcode implies
    typedef union packed {
        rFormatT r;
        iFormatT i;
        jFormatT j;
    } instrWordT;

    typedef struct packed {
        logic                    pcAdvance;    // pc + 4
        logic                    pcBranch;     // Taken BEQ/BNE
        logic                    pcJump;       // J or JR
        logic                    resultLoad;   // ALU output into result
        logic                    loadCapture;  // readdata into result
        logic                    regWrite;
        logic [regAddrWidth-1:0] destReg;
    } cpuCtrlT;

endpackage
